// ==== verilog/chroni_pkg.sv ====
package chroni_pkg;

   // memories
   localparam int vram_aw     = 17;
   localparam int vram_bytes  = 1 << vram_aw;
   localparam int pal_entries = 256;
   localparam int vram_rd_lat = 2;   // address out to data valid

   // cpu register window at 0x9000
   localparam logic [11:0] reg_page      = 12'h900;
   localparam logic [3:0]  reg_dl_lo     = 4'h0;
   localparam logic [3:0]  reg_dl_hi     = 4'h1;
   localparam logic [3:0]  reg_charset   = 4'h2;
   localparam logic [3:0]  reg_pal_index = 4'h4;
   localparam logic [3:0]  reg_pal_data  = 4'h5;
   localparam logic [3:0]  reg_vaddr_lo  = 4'h6;
   localparam logic [3:0]  reg_vaddr_mid = 4'h7;
   localparam logic [3:0]  reg_vaddr_hi  = 4'h8;
   localparam logic [3:0]  reg_vdata     = 4'h9;

   // text geometry
   localparam int text_cols  = 80;
   localparam int char_lines = 8;
   localparam int col_w      = 7;
   localparam int pix_aw     = 10;

   // display list instructions
   localparam logic [3:0] dl_end     = 4'd1;
   localparam int         dl_lms_bit = 6;

   localparam logic [1:0] pal_idle  = 2'd0;
   localparam logic [1:0] pal_lo    = 2'd1;
   localparam logic [1:0] pal_hi    = 2'd2;
   localparam logic [1:0] pal_write = 2'd3;

   localparam logic [2:0] dl_idle = 3'd0;
   localparam logic [2:0] dl_read = 3'd1;
   localparam logic [2:0] dl_wait = 3'd2;
   localparam logic [2:0] dl_exec = 3'd3;
   localparam logic [2:0] dl_halt = 3'd4;   // end code seen, wait for next frame

   localparam logic [2:0] fd_idle  = 3'd0;
   localparam logic [2:0] fd_text  = 3'd1;
   localparam logic [2:0] fd_attr  = 3'd2;
   localparam logic [2:0] fd_prime = 3'd3;
   localparam logic [2:0] fd_fetch = 3'd4;
   localparam logic [2:0] fd_wait  = 3'd5;
   localparam logic [2:0] fd_emit  = 3'd6;
   localparam logic [2:0] fd_done  = 3'd7;

endpackage

// ==== verilog/chroni_spram.sv ====
`timescale 1ns/1ps

module chroni_spram
   import chroni_pkg::*;
(
   input  logic             sys_clk,
   input  logic [col_w-1:0] addr,
   input  logic             wr_en,
   input  logic [7:0]       wr_data,
   output logic [7:0]       rd_data
);

   logic [7:0] mem [0:text_cols-1];

   always_ff @(posedge sys_clk) begin
      if (wr_en)
         mem[addr] <= wr_data;
      rd_data <= mem[addr];
   end

endmodule

// ==== verilog/chroni_vram.sv ====
`timescale 1ns/1ps

module chroni_vram
   import chroni_pkg::*;
(
   input  logic               sys_clk,
   input  logic               wr_en,
   input  logic [vram_aw-1:0] wr_addr,
   input  logic [7:0]         wr_data,
   input  logic [vram_aw-1:0] rd_addr,
   output logic [7:0]         rd_data
);

   logic [7:0]         mem [0:vram_bytes-1];
   logic [vram_aw-1:0] rd_addr_q;

   always_ff @(posedge sys_clk) begin
      if (wr_en)
         mem[wr_addr] <= wr_data;
      rd_addr_q <= rd_addr;         // address register, then output register
      rd_data   <= mem[rd_addr_q];
   end

endmodule

// ==== verilog/chroni_regs.sv ====
`timescale 1ns/1ps

module chroni_regs
   import chroni_pkg::*;
(
   input  logic               sys_clk,
   input  logic               rst_n,
   input  logic [15:0]        cpu_addr,
   input  logic [7:0]         cpu_wr_data,
   input  logic               cpu_wr_en,
   output logic [vram_aw-1:0] dl_addr,
   output logic [7:0]         charset_base,
   output logic               pal_index_wr,
   output logic               pal_data_wr,
   output logic [7:0]         pal_wr_byte,
   output logic               vram_wr_en,
   output logic [vram_aw-1:0] vram_wr_addr,
   output logic [7:0]         vram_wr_data
);

   logic               reg_wr;
   logic [3:0]         offset;
   logic [vram_aw-2:0] dl_word;     // display list sits on an even address
   logic [vram_aw-1:0] port_addr;

   assign reg_wr = cpu_wr_en && cpu_addr[15:4] == reg_page;
   assign offset = cpu_addr[3:0];
   assign dl_addr = {dl_word, 1'b0};

   // palette writes go straight through to the loader
   assign pal_index_wr = reg_wr && offset == reg_pal_index;
   assign pal_data_wr  = reg_wr && offset == reg_pal_data;
   assign pal_wr_byte  = cpu_wr_data;

   always_ff @(posedge sys_clk) begin
      vram_wr_en <= 1'b0;
      if (!rst_n) begin
         dl_word      <= '0;
         charset_base <= '0;
         port_addr    <= '0;
      end else if (reg_wr) begin
         case (offset)
            reg_dl_lo:     dl_word[7:0]    <= cpu_wr_data;
            reg_dl_hi:     dl_word[15:8]   <= cpu_wr_data;
            reg_charset:   charset_base    <= cpu_wr_data;
            reg_vaddr_lo:  port_addr[7:0]  <= cpu_wr_data;
            reg_vaddr_mid: port_addr[15:8] <= cpu_wr_data;
            reg_vaddr_hi:  port_addr[16]   <= cpu_wr_data[0];
            reg_vdata: begin
               vram_wr_en <= 1'b1;
               port_addr  <= port_addr + 1'b1;   // auto increment
            end
            default: ;
         endcase
      end
   end

   always_ff @(posedge sys_clk) begin
      if (reg_wr && offset == reg_vdata) begin
         vram_wr_addr <= port_addr;
         vram_wr_data <= cpu_wr_data;
      end
   end

endmodule

// ==== verilog/chroni_palette.sv ====
`timescale 1ns/1ps

module chroni_palette
   import chroni_pkg::*;
(
   input  logic        sys_clk,
   input  logic        rst_n,
   input  logic        pal_index_wr,
   input  logic        pal_data_wr,
   input  logic [7:0]  pal_wr_byte,
   input  logic [7:0]  palette_rd_addr,
   output logic [15:0] palette_rd_data
);

   logic [1:0]  state;
   logic [7:0]  index;
   logic [15:0] entry;
   logic [15:0] mem [0:pal_entries-1];

   always_ff @(posedge sys_clk) begin
      if (!rst_n) begin
         state <= pal_idle;
      end else if (pal_index_wr) begin
         state <= pal_lo;
      end else begin
         case (state)
            pal_lo:    if (pal_data_wr) state <= pal_hi;
            pal_hi:    if (pal_data_wr) state <= pal_write;
            pal_write: state <= pal_data_wr ? pal_hi : pal_lo;   // next pair may follow at once
            default: ;
         endcase
      end
   end

   always_ff @(posedge sys_clk) begin
      if (pal_index_wr)
         index <= pal_wr_byte;
      else if (state == pal_write)
         index <= index + 1'b1;
      if (pal_data_wr && state != pal_hi)
         entry[7:0] <= pal_wr_byte;
      if (pal_data_wr && state == pal_hi)
         entry[15:8] <= pal_wr_byte;
      if (state == pal_write)
         mem[index] <= entry;
      palette_rd_data <= mem[palette_rd_addr];
   end

   // the index register must be written before any colour data
   assert property (@(posedge sys_clk) disable iff (!rst_n) pal_data_wr |-> state != pal_idle);

endmodule

// ==== verilog/chroni_dlist.sv ====
`timescale 1ns/1ps

module chroni_dlist
   import chroni_pkg::*;
(
   input  logic               sys_clk,
   input  logic               rst_n,
   input  logic               frame_start,
   input  logic               line_start,
   input  logic [vram_aw-1:0] dl_addr,
   input  logic [7:0]         vram_rd_data,
   output logic [vram_aw-1:0] dl_rd_addr,
   output logic               dl_reading,
   output logic               render,
   output logic               lms_changed,
   output logic [vram_aw-1:0] text_base,
   output logic [vram_aw-1:0] attr_base,
   output logic               blank_line
);

   logic [2:0]         state;
   logic [vram_aw-1:0] dl_ptr;
   logic [1:0]         wait_cnt;
   logic [2:0]         part;        // 0 is the opcode, 1 to 6 are lms bytes
   logic [2:0]         scanlines;   // lines left in the current row
   logic               lms_pending;

   always_ff @(posedge sys_clk) begin
      render      <= 1'b0;
      lms_changed <= 1'b0;
      if (!rst_n || frame_start) begin
         state       <= dl_idle;
         dl_ptr      <= dl_addr;
         dl_reading  <= 1'b0;
         scanlines   <= '0;
         lms_pending <= 1'b0;
         blank_line  <= 1'b1;
      end else if (line_start) begin
         blank_line <= 1'b1;
         if (scanlines != 0) begin
            scanlines  <= scanlines - 1'b1;
            render     <= 1'b1;
            blank_line <= 1'b0;
         end else if (state != dl_halt) begin
            part  <= '0;
            state <= dl_read;
         end
      end else begin
         case (state)
            dl_read: begin
               dl_rd_addr <= dl_ptr;
               dl_ptr     <= dl_ptr + 1'b1;
               dl_reading <= 1'b1;
               wait_cnt   <= 2'(vram_rd_lat);
               state      <= dl_wait;
            end
            dl_wait: begin
               if (wait_cnt != 0) begin
                  wait_cnt <= wait_cnt - 1'b1;
               end else if (part == 0) begin
                  if (vram_rd_data[dl_lms_bit]) begin
                     part  <= 3'd1;
                     state <= dl_read;
                  end else if (vram_rd_data[3:0] == dl_end) begin
                     dl_reading <= 1'b0;
                     state      <= dl_halt;
                  end else begin
                     state <= dl_exec;
                  end
               end else begin
                  case (part)
                     3'd1: text_base[7:0]  <= vram_rd_data;
                     3'd2: text_base[15:8] <= vram_rd_data;
                     3'd3: text_base[16]   <= vram_rd_data[0];
                     3'd4: attr_base[7:0]  <= vram_rd_data;
                     3'd5: attr_base[15:8] <= vram_rd_data;
                     default: attr_base[16] <= vram_rd_data[0];
                  endcase
                  if (part == 3'd6) begin
                     lms_pending <= 1'b1;
                     state       <= dl_exec;
                  end else begin
                     part  <= part + 1'b1;
                     state <= dl_read;
                  end
               end
            end
            dl_exec: begin
               render      <= 1'b1;
               lms_changed <= lms_pending;
               lms_pending <= 1'b0;
               blank_line  <= 1'b0;
               scanlines   <= 3'(char_lines - 1);
               dl_reading  <= 1'b0;
               state       <= dl_idle;
            end
            default: ;
         endcase
      end
   end

   // the fetcher owns the vram read port once a line renders
   assert property (@(posedge sys_clk) disable iff (!rst_n) !(render && dl_reading));

endmodule

// ==== verilog/chroni_text_fetch.sv ====
`timescale 1ns/1ps

module chroni_text_fetch
   import chroni_pkg::*;
(
   input  logic               sys_clk,
   input  logic               rst_n,
   input  logic               frame_start,
   input  logic               render,
   input  logic               lms_changed,
   input  logic [vram_aw-1:0] text_base,
   input  logic [vram_aw-1:0] attr_base,
   input  logic [7:0]         charset_base,
   input  logic [7:0]         vram_rd_data,
   output logic [vram_aw-1:0] fetch_rd_addr,
   output logic               pix_wr_en,
   output logic [pix_aw-1:0]  pix_addr,
   output logic [7:0]         pix_data,
   output logic [3:0]         pix_fg,
   output logic [3:0]         pix_bg
);

   logic [2:0]         state;
   logic [2:0]         font_line;
   logic [vram_aw-1:0] row_text;
   logic [vram_aw-1:0] row_attr;
   logic [vram_aw-1:0] rd_ptr;
   logic [1:0]         wait_cnt;
   logic [col_w-1:0]   col;         // buffer index for both fill and draw
   logic [7:0]         code;
   logic [7:0]         attr;
   logic [6:0]         font_hi;
   logic               text_we;
   logic               attr_we;

   assign text_we = state == fd_text && wait_cnt == 0;
   assign attr_we = state == fd_attr && wait_cnt == 0;
   assign font_hi = charset_base[6:0] + 7'(code[7]);   // upper 128 codes use next charset

   chroni_spram text_buf (
      .sys_clk (sys_clk),
      .addr    (col),
      .wr_en   (text_we),
      .wr_data (vram_rd_data),
      .rd_data (code)
   );

   chroni_spram attr_buf (
      .sys_clk (sys_clk),
      .addr    (col),
      .wr_en   (attr_we),
      .wr_data (vram_rd_data),
      .rd_data (attr)
   );

   always_ff @(posedge sys_clk) begin
      pix_wr_en <= 1'b0;
      if (!rst_n || frame_start) begin
         state     <= fd_idle;
         font_line <= '0;
      end else begin
         case (state)
            fd_idle: if (render) begin
               col      <= '0;
               wait_cnt <= 2'(vram_rd_lat + 1);
               if (lms_changed) begin
                  row_text <= text_base;
                  row_attr <= attr_base;
                  rd_ptr   <= text_base;
               end else begin
                  rd_ptr <= row_text;
               end
               state <= (font_line == 0) ? fd_text : fd_prime;
            end
            fd_text, fd_attr: begin
               // one address per cycle, data lands vram_rd_lat+1 cycles later
               fetch_rd_addr <= rd_ptr;
               rd_ptr        <= rd_ptr + 1'b1;
               if (wait_cnt != 0) begin
                  wait_cnt <= wait_cnt - 1'b1;
               end else if (col == col_w'(text_cols - 1)) begin
                  col      <= '0;
                  wait_cnt <= 2'(vram_rd_lat + 1);
                  rd_ptr   <= row_attr;
                  state    <= (state == fd_text) ? fd_attr : fd_prime;
               end else begin
                  col <= col + 1'b1;
               end
            end
            fd_prime: state <= fd_fetch;   // buffer read in flight
            fd_fetch: begin
               fetch_rd_addr <= {font_hi, code[6:0], font_line};
               wait_cnt      <= 2'(vram_rd_lat);
               state         <= fd_wait;
            end
            fd_wait: begin
               if (wait_cnt != 0)
                  wait_cnt <= wait_cnt - 1'b1;
               else
                  state <= fd_emit;
            end
            fd_emit: begin
               pix_wr_en <= 1'b1;
               pix_addr  <= {col, 3'b000};
               pix_data  <= vram_rd_data;
               pix_fg    <= attr[3:0];
               pix_bg    <= attr[7:4];
               state     <= fd_done;
            end
            default: begin
               if (col == col_w'(text_cols - 1)) begin
                  font_line <= font_line + 1'b1;
                  if (font_line == 3'(char_lines - 1)) begin
                     row_text <= row_text + vram_aw'(text_cols);
                     row_attr <= row_attr + vram_aw'(text_cols);
                  end
                  state <= fd_idle;
               end else begin
                  col   <= col + 1'b1;
                  state <= fd_prime;
               end
            end
         endcase
      end
   end

   // line spacing from the display list must cover a whole row fetch
   assert property (@(posedge sys_clk) disable iff (!rst_n) render |-> state == fd_idle);
   assert property (@(posedge sys_clk) disable iff (!rst_n)
      pix_wr_en |-> pix_addr < pix_aw'(text_cols * 8));

endmodule

// ==== verilog/chroni.sv ====
`timescale 1ns/1ps

module chroni
   import chroni_pkg::*;
(
   input  logic              sys_clk,
   input  logic              rst_n,
   input  logic [15:0]       cpu_addr,
   input  logic [7:0]        cpu_wr_data,
   input  logic              cpu_wr_en,
   input  logic              frame_start,
   input  logic              line_start,
   input  logic [7:0]        palette_rd_addr,
   output logic              pix_wr_en,
   output logic [pix_aw-1:0] pix_addr,
   output logic [7:0]        pix_data,
   output logic [3:0]        pix_fg,
   output logic [3:0]        pix_bg,
   output logic              blank_line,
   output logic [15:0]       palette_rd_data
);

   logic [vram_aw-1:0] dl_addr;
   logic [7:0]         charset_base;
   logic               pal_index_wr;
   logic               pal_data_wr;
   logic [7:0]         pal_wr_byte;
   logic               vram_wr_en;
   logic [vram_aw-1:0] vram_wr_addr;
   logic [7:0]         vram_wr_data;
   logic [vram_aw-1:0] vram_rd_addr;
   logic [7:0]         vram_rd_data;
   logic [vram_aw-1:0] dl_rd_addr;
   logic               dl_reading;
   logic [vram_aw-1:0] fetch_rd_addr;
   logic               render;
   logic               lms_changed;
   logic [vram_aw-1:0] text_base;
   logic [vram_aw-1:0] attr_base;

   assign vram_rd_addr = dl_reading ? dl_rd_addr : fetch_rd_addr;

   chroni_regs regs_i (
      .sys_clk, .rst_n, .cpu_addr, .cpu_wr_data, .cpu_wr_en,
      .dl_addr, .charset_base, .pal_index_wr, .pal_data_wr, .pal_wr_byte,
      .vram_wr_en, .vram_wr_addr, .vram_wr_data
   );

   chroni_palette palette_i (
      .sys_clk, .rst_n, .pal_index_wr, .pal_data_wr, .pal_wr_byte,
      .palette_rd_addr, .palette_rd_data
   );

   chroni_vram vram_i (
      .sys_clk (sys_clk),
      .wr_en   (vram_wr_en),
      .wr_addr (vram_wr_addr),
      .wr_data (vram_wr_data),
      .rd_addr (vram_rd_addr),
      .rd_data (vram_rd_data)
   );

   chroni_dlist dlist_i (
      .sys_clk, .rst_n, .frame_start, .line_start, .dl_addr, .vram_rd_data,
      .dl_rd_addr, .dl_reading, .render, .lms_changed, .text_base, .attr_base,
      .blank_line
   );

   chroni_text_fetch fetch_i (
      .sys_clk, .rst_n, .frame_start, .render, .lms_changed, .text_base,
      .attr_base, .charset_base, .vram_rd_data, .fetch_rd_addr,
      .pix_wr_en, .pix_addr, .pix_data, .pix_fg, .pix_bg
   );

endmodule

// ==== bench/chroni_tb.sv ====
`timescale 1ns/1ps

module chroni_tb
   import chroni_pkg::*;
();

   localparam int line_gap        = 1200;   // cycles between line_start pulses
   localparam int model_size      = 4096;   // dl, text, attr and both fonts sit below 0x1000
   localparam int test_lines      = 20;
   localparam int load_cycles     = model_size + 300;
   localparam int watchdog_cycles = test_lines * (line_gap + 8) + load_cycles;
   localparam logic [vram_aw-1:0] dl_base   = 17'h00100;
   localparam logic [vram_aw-1:0] text_row0 = 17'h00200;
   localparam logic [vram_aw-1:0] attr_row0 = 17'h00400;
   localparam logic [7:0]         charset   = 8'h02;   // fonts at 0x800 and 0xc00
   localparam logic [7:0]         pal_first = 8'h10;

   logic               sys_clk = 1'b0;
   logic               rst_n;
   logic [15:0]        cpu_addr;
   logic [7:0]         cpu_wr_data;
   logic               cpu_wr_en;
   logic               frame_start;
   logic               line_start;
   logic [7:0]         palette_rd_addr;
   logic               pix_wr_en;
   logic [pix_aw-1:0]  pix_addr;
   logic [7:0]         pix_data;
   logic [3:0]         pix_fg;
   logic [3:0]         pix_bg;
   logic               blank_line;
   logic [15:0]        palette_rd_data;

   logic [7:0]         vram_model [0:model_size-1];
   logic [15:0]        pal_model [0:2];
   logic [15:0]        lfsr;
   int                 errors;
   int                 checks;
   int                 col_count;     // pixel writes seen in the current line
   int                 line_writes;
   int                 line_font;
   int                 high_codes;
   logic [vram_aw-1:0] line_text;
   logic [vram_aw-1:0] line_attr;
   logic [7:0]         mon_code;
   logic [7:0]         mon_attr;
   logic [vram_aw-1:0] mon_font_addr;

   chroni chroni_i (
      .sys_clk, .rst_n, .cpu_addr, .cpu_wr_data, .cpu_wr_en, .frame_start,
      .line_start, .palette_rd_addr, .pix_wr_en, .pix_addr, .pix_data, .pix_fg,
      .pix_bg, .blank_line, .palette_rd_data
   );

   always #2 sys_clk = ~sys_clk;

   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
   endfunction

   task automatic rand_byte(output logic [7:0] b);
      for (int i = 0; i < 8; i++) begin
         b    = {b[6:0], lfsr[0]};   // one step per bit
         lfsr = lfsr_next(lfsr);
      end
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("** Error at time %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
      end
   endtask

   task automatic write_reg(input logic [3:0] offset, input logic [7:0] data);
      @(negedge sys_clk);
      cpu_addr    = {reg_page, offset};
      cpu_wr_data = data;
      cpu_wr_en   = 1'b1;
   endtask

   task automatic bus_idle();
      @(negedge sys_clk);
      cpu_wr_en = 1'b0;
   endtask

   task automatic restart_frame();
      @(negedge sys_clk);
      frame_start = 1'b1;
      @(negedge sys_clk);
      frame_start = 1'b0;
   endtask

   task automatic load_vram();
      logic [7:0] b;
      for (int a = 0; a < model_size; a++) begin
         rand_byte(b);
         vram_model[a] = b;
      end
      vram_model[dl_base]     = 8'h42;   // lms row
      vram_model[dl_base + 1] = text_row0[7:0];
      vram_model[dl_base + 2] = text_row0[15:8];
      vram_model[dl_base + 3] = {7'd0, text_row0[16]};
      vram_model[dl_base + 4] = attr_row0[7:0];
      vram_model[dl_base + 5] = attr_row0[15:8];
      vram_model[dl_base + 6] = {7'd0, attr_row0[16]};
      vram_model[dl_base + 7] = 8'h02;   // plain row
      vram_model[dl_base + 8] = {4'h0, dl_end};
      write_reg(reg_vaddr_lo, 8'h00);
      write_reg(reg_vaddr_mid, 8'h00);
      write_reg(reg_vaddr_hi, 8'h00);
      for (int a = 0; a < model_size; a++)
         write_reg(reg_vdata, vram_model[a]);
      write_reg(reg_dl_lo, dl_base[8:1]);
      write_reg(reg_dl_hi, dl_base[16:9]);
      write_reg(reg_charset, charset);
      bus_idle();
   endtask

   // pulses line_start, waits for the writes and keeps the line spacing
   task automatic run_line(input logic [vram_aw-1:0] text, input logic [vram_aw-1:0] attr,
                           input int font, input int writes);
      int n;
      int got;
      @(posedge sys_clk);
      line_text   = text;
      line_attr   = attr;
      line_font   = font;
      line_writes = writes;
      col_count   = 0;
      @(negedge sys_clk);
      line_start = 1'b1;
      @(negedge sys_clk);
      line_start = 1'b0;
      n = 0;
      do begin
         @(posedge sys_clk);
         n++;
      end while (col_count < writes && n < line_gap);
      got = col_count;
      if (got < writes) begin
         errors++;
         $display("only %0d of %0d pixel writes arrived for font line %0d", got, writes, font);
      end
      while (n < line_gap) begin
         @(posedge sys_clk);
         n++;
      end
      @(negedge sys_clk);
      check_value("blank_line", blank_line, writes == 0);
   endtask

   task automatic palette_test();
      logic [7:0] lo;
      logic [7:0] hi;
      write_reg(reg_pal_index, pal_first);
      for (int i = 0; i < 3; i++) begin
         rand_byte(lo);
         rand_byte(hi);
         pal_model[i] = {hi, lo};
         write_reg(reg_pal_data, lo);
         write_reg(reg_pal_data, hi);
      end
      bus_idle();
      repeat (2) @(negedge sys_clk);
      for (int i = 0; i < 3; i++) begin
         palette_rd_addr = pal_first + 8'(i);   // consecutive entries from one index write
         @(negedge sys_clk);
         check_value("palette_rd_data", palette_rd_data, pal_model[i]);
      end
   endtask

   task automatic first_row_test();
      run_line(text_row0, attr_row0, 0, text_cols);
   endtask

   task automatic font_lines_test();
      for (int l = 1; l < char_lines; l++)
         run_line(text_row0, attr_row0, l, text_cols);
   endtask

   task automatic row_advance_test();
      for (int l = 0; l < char_lines; l++)
         run_line(text_row0 + text_cols, attr_row0 + text_cols, l, text_cols);
      repeat (3) run_line(text_row0, attr_row0, 0, 0);   // list has ended
      restart_frame();
      run_line(text_row0, attr_row0, 0, text_cols);
   endtask

   // checks each pixel write against the vram model
   always @(negedge sys_clk) begin
      if (pix_wr_en === 1'b1) begin
         if (col_count >= line_writes) begin
            errors++;
            $display("unexpected pixel write at time %0t, pix_addr %0d", $time, pix_addr);
         end else begin
            mon_code      = vram_model[line_text + col_count];
            mon_attr      = vram_model[line_attr + col_count];
            // 1K bytes per charset with the upper 128 codes in the next one
            mon_font_addr = vram_aw'(charset[6:0]) * 1024 + vram_aw'(mon_code) * 8
                            + vram_aw'(line_font);
            if (mon_code[7])
               high_codes++;
            check_value("pix_addr", pix_addr, col_count * 8);
            check_value("pix_data", pix_data, vram_model[mon_font_addr]);
            check_value("pix_fg", pix_fg, mon_attr[3:0]);
            check_value("pix_bg", pix_bg, mon_attr[7:4]);
         end
         col_count++;
      end
   end

   initial begin
      repeat (watchdog_cycles) @(posedge sys_clk);
      $display("watchdog expired after %0d cycles, the tests did not complete", watchdog_cycles);
      $display("checks: %0d, errors: %0d", checks, errors);
      $display("TEST FAILED");
      $finish;
   end

   initial begin
      lfsr            = 16'd90;
      errors          = 0;
      checks          = 0;
      col_count       = 0;
      line_writes     = 0;
      line_font       = 0;
      high_codes      = 0;
      rst_n           = 1'b0;
      cpu_addr        = '0;
      cpu_wr_data     = '0;
      cpu_wr_en       = 1'b0;
      frame_start     = 1'b0;
      line_start      = 1'b0;
      palette_rd_addr = '0;
      repeat (2) @(negedge sys_clk);
      rst_n = 1'b1;
      check_value("blank_line", blank_line, 1);
      check_value("pix_wr_en", pix_wr_en, 0);

      palette_test();
      load_vram();
      restart_frame();
      first_row_test();
      font_lines_test();
      row_advance_test();
      check_value("codes with bit 7 set", high_codes != 0, 1);

      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

// ==== sources.f ====
verilog/chroni_pkg.sv
verilog/chroni_spram.sv
verilog/chroni_vram.sv
verilog/chroni_regs.sv
verilog/chroni_palette.sv
verilog/chroni_dlist.sv
verilog/chroni_text_fetch.sv
verilog/chroni.sv
bench/chroni_tb.sv
